/* rtl/quad_ctrl_pkg.sv */
package quad_ctrl_pkg;

    ////////////////////
    // Sizes and timing
    ////////////////////

    // One buffer memory
    localparam int BRAM_DEPTH = 1024;
    // Row or column index, half the buffer address
    localparam int POS_W = $clog2(BRAM_DEPTH) - 1;
    // 4 engine groups of 2
    localparam int NUM_CE = 8;
    // Rows drained before execution
    localparam int PRIME_ROWS = 3;
    // Sequence reads making up one output pixel
    localparam int SEQ_READS_PER_PIXEL = 5;
    // Sequence read to first execute pulse
    localparam int SEQ_READ_LATENCY = 2;
    // Stretched accept pulse
    localparam int ACCEPT_CYCLES = 5;
    localparam int SEQ_ADDR_W = 12;

    // Pixel cycle counter
    localparam int CYC_W = $clog2(SEQ_READS_PER_PIXEL);
    localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(SEQ_READS_PER_PIXEL - 1);

    ////////////////////
    // Types
    ////////////////////

    typedef logic [POS_W-1:0] pos_t;
    // One extra bit so a full row fits
    typedef logic [POS_W:0] word_count_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;
    typedef logic [NUM_CE-1:0] ce_vec_t;
    typedef logic [1:0] gray_t;

    typedef enum logic [2:0] {
        st_idle,
        st_prime,
        st_wait_fetch,
        st_active,
        st_done
    } job_state_t;

    // Latched at accept
    typedef struct packed {
        pos_t last_row;
        pos_t last_col;
    } job_dims_t;

    // Input side back to the job FSM
    typedef struct packed {
        logic buffer_empty;
        pos_t cur_row;
        logic last_row_fetched;
        logic fetch_in_progress;
    } tracker_status_t;

    // Execution side back to the job FSM
    typedef struct packed {
        logic pixel_done;
        logic row_done;
        logic last_pixel_done;
        logic reads_pending;
    } seq_status_t;

endpackage

/* rtl/input_row_tracker.sv */
`timescale 1ns/1ps

module input_row_tracker import quad_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  job_state_t      phase,
    input  job_dims_t       dims,
    input  logic            word_take,
    input  logic            job_fetch_ack,
    input  logic            job_fetch_complete,
    output logic            job_fetch_request,
    output logic            job_fetch_in_progress,
    output logic            pfb_rden,
    output gray_t           gray_code,
    output tracker_status_t status
);

    word_count_t word_count;
    pos_t        input_row;
    pos_t        input_col;
    pos_t        fetch_row;
    logic        last_fetched;
    logic        buffer_empty;
    logic        fetch_phase;
    logic        fetch_acked;
    logic        row_end;
    gray_t       bank_cnt;

    assign buffer_empty = (word_count == '0);
    // Fetches only run while a job is in flight
    assign fetch_phase = (phase == st_prime) || (phase == st_wait_fetch) ||
                         (phase == st_active);
    assign fetch_acked = job_fetch_request && job_fetch_ack;

    // Prime drains a word per cycle, active one per pixel
    assign pfb_rden = ((phase == st_prime) && !buffer_empty) || word_take;
    // Last word of the buffered row
    assign row_end = pfb_rden && (input_col == dims.last_col);

    ////////////////////
    // Fetch exchange
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            fetch_row             <= '0;
            last_fetched          <= 1'b0;
        end else begin
            // Request holds through a late ack
            if (fetch_acked) begin
                job_fetch_request <= 1'b0;
            end else if (!job_fetch_request && !job_fetch_in_progress && buffer_empty &&
                         !last_fetched && fetch_phase) begin
                job_fetch_request <= 1'b1;
            end
            if (fetch_acked) begin
                job_fetch_in_progress <= 1'b1;
            end else if (job_fetch_in_progress && job_fetch_complete) begin
                job_fetch_in_progress <= 1'b0;
            end
            // Row number of the next fetch
            if (phase == st_idle) begin
                fetch_row    <= '0;
                last_fetched <= 1'b0;
            end else if (fetch_acked) begin
                fetch_row <= fetch_row + 1'b1;
                if (fetch_row == dims.last_row) begin
                    last_fetched <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Buffer words
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            word_count <= '0;
            input_row  <= '0;
            input_col  <= '0;
            bank_cnt   <= '0;
        end else begin
            // Full row lands on complete
            if (job_fetch_in_progress && job_fetch_complete) begin
                word_count <= word_count_t'(dims.last_col) + 1'b1;
            end else if (pfb_rden) begin
                word_count <= word_count - 1'b1;
            end
            if (phase == st_idle) begin
                input_row <= '0;
                input_col <= '0;
            end else if (row_end) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else if (pfb_rden) begin
                input_col <= input_col + 1'b1;
            end
            // Bank flips per drained row, kept across jobs
            if (row_end) begin
                bank_cnt <= bank_cnt + 1'b1;
            end
        end
    end

    assign gray_code = {bank_cnt[1], bank_cnt[1] ^ bank_cnt[0]};

    assign status.buffer_empty      = buffer_empty;
    assign status.cur_row           = input_row;
    assign status.last_row_fetched  = last_fetched;
    assign status.fetch_in_progress = job_fetch_in_progress;

    // Pixel ends from the sequencer only land on a loaded buffer
    a_rden_nonzero: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (word_count != '0));

    // One row in flight, each request is for the row after the last one drained
    a_fetch_single: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request |-> (fetch_row == input_row));

endmodule

/* rtl/exec_sequencer.sv */
`timescale 1ns/1ps

module exec_sequencer import quad_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  job_state_t  phase,
    input  job_dims_t   dims,
    input  logic        buffer_empty,
    output logic        seq_rden,
    output seq_addr_t   seq_rd_addr,
    output ce_vec_t     ce_execute,
    output logic        word_take,
    output seq_status_t status
);

    logic [CYC_W-1:0]            cyc_cnt;
    logic [SEQ_READ_LATENCY-1:0] rd_pipe;
    logic [NUM_CE-1:1]           ce_tail;
    pos_t                        out_row;
    pos_t                        out_col;
    pos_t                        last_out_row;
    logic                        last_done;
    logic                        pixel_end;
    logic                        row_end;

    // Primed rows produce no output row of their own
    assign last_out_row = dims.last_row - pos_t'(PRIME_ROWS);

    ////////////////////
    // Pixel reads
    ////////////////////

    // Buffer holds its word until the pixel ends, so a started
    // pixel always runs its full burst
    assign seq_rden  = (phase == st_active) && !buffer_empty && !last_done;
    assign pixel_end = seq_rden && (cyc_cnt == CYC_LAST);
    assign row_end   = pixel_end && (out_col == dims.last_col);
    assign word_take = pixel_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt     <= '0;
            seq_rd_addr <= '0;
            out_row     <= '0;
            out_col     <= '0;
            last_done   <= 1'b0;
        end else if (phase == st_idle) begin
            cyc_cnt     <= '0;
            seq_rd_addr <= '0;
            out_row     <= '0;
            out_col     <= '0;
            last_done   <= 1'b0;
        end else if (seq_rden) begin
            if (pixel_end) begin
                cyc_cnt <= '0;
                if (row_end) begin
                    // Next output row reuses the same sequence
                    out_col     <= '0;
                    out_row     <= out_row + 1'b1;
                    seq_rd_addr <= '0;
                    if (out_row == last_out_row) begin
                        last_done <= 1'b1;
                    end
                end else begin
                    out_col     <= out_col + 1'b1;
                    seq_rd_addr <= seq_rd_addr + 1'b1;
                end
            end else begin
                cyc_cnt     <= cyc_cnt + 1'b1;
                seq_rd_addr <= seq_rd_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // Execute chain
    ////////////////////

    // Covers the sequence memory read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
            ce_tail <= '0;
        end else begin
            rd_pipe <= {rd_pipe[SEQ_READ_LATENCY-2:0], seq_rden};
            // Each engine one cycle behind its neighbour
            ce_tail <= ce_execute[NUM_CE-2:0];
        end
    end

    assign ce_execute = {ce_tail, rd_pipe[SEQ_READ_LATENCY-1]};

    assign status.pixel_done      = pixel_end;
    assign status.row_done        = row_end;
    assign status.last_pixel_done = last_done;
    // Mid-pixel or still in the read pipe
    assign status.reads_pending   = (cyc_cnt != '0) || (|rd_pipe);

    // Execution only in active or while the pipe drains into a fetch wait
    a_exec_in_active: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] |-> ((phase == st_active) || (phase == st_wait_fetch)));

endmodule

/* rtl/job_fsm.sv */
`timescale 1ns/1ps

module job_fsm import quad_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            job_start,
    input  job_dims_t       dims_in,
    input  tracker_status_t trk,
    input  seq_status_t     seq,
    input  logic            job_complete_ack,
    output logic            job_accept,
    output logic            job_complete,
    output job_state_t      phase,
    output job_dims_t       dims
);

    job_state_t               state;
    job_state_t               next_state;
    job_state_t               ret_state;
    logic                     start_take;
    logic                     fetch_pending;
    logic                     prime_done;
    logic [ACCEPT_CYCLES-1:0] accept_sr;

    assign phase = state;
    // job_start only counts in idle
    assign start_take = (state == st_idle) && job_start;
    // A row is on its way or still to be requested
    assign fetch_pending = trk.fetch_in_progress || !trk.last_row_fetched;
    assign prime_done = (trk.cur_row == pos_t'(PRIME_ROWS));

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (job_start) begin
                    next_state = st_prime;
                end
            end
            st_prime: begin
                // Drained rows win over a pending fetch
                if (prime_done) begin
                    next_state = st_active;
                end else if (trk.buffer_empty && fetch_pending) begin
                    next_state = st_wait_fetch;
                end
            end
            st_wait_fetch: begin
                // Row loaded, go back where we were
                if (!trk.buffer_empty) begin
                    next_state = ret_state;
                end
            end
            st_active: begin
                if (seq.last_pixel_done && !seq.reads_pending) begin
                    next_state = st_done;
                end else if (trk.buffer_empty && fetch_pending) begin
                    next_state = st_wait_fetch;
                end
            end
            st_done: begin
                if (job_complete_ack) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    ////////////////////
    // State and job exchange
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            ret_state    <= st_prime;
            accept_sr    <= '0;
            job_complete <= 1'b0;
        end else begin
            state <= next_state;
            // Remember prime or active across the fetch wait
            if ((next_state == st_wait_fetch) && (state != st_wait_fetch)) begin
                ret_state <= state;
            end
            // Stretch accept over ACCEPT_CYCLES
            accept_sr <= {accept_sr[ACCEPT_CYCLES-2:0], start_take};
            // Level for as long as done lasts
            job_complete <= (next_state == st_done);
        end
    end

    // Job dims held for the whole job
    always_ff @(posedge clk) begin
        if (start_take) begin
            dims <= dims_in;
        end
    end

    assign job_accept = |accept_sr;

    // Next job never taken while the previous accept pulse still runs
    a_accept_window: assert property (@(posedge clk) disable iff (rst)
        start_take |-> !job_accept);

    // Pixels consume buffered words, and a finished output row empties the buffer
    a_pixel_word: assert property (@(posedge clk) disable iff (rst)
        seq.pixel_done |-> !trk.buffer_empty);
    a_row_drained: assert property (@(posedge clk) disable iff (rst)
        seq.row_done |=> trk.buffer_empty);

endmodule

/* rtl/quad_bram_ctrl.sv */
`timescale 1ns/1ps

module quad_bram_ctrl import quad_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  job_dims_t  job_dims,
    input  logic       job_start,
    output logic       job_accept,
    output logic       job_fetch_request,
    input  logic       job_fetch_ack,
    input  logic       job_fetch_complete,
    output logic       job_fetch_in_progress,
    output logic       pfb_rden,
    output gray_t      gray_code,
    output logic       seq_rden,
    output seq_addr_t  seq_rd_addr,
    output ce_vec_t    ce_execute,
    output logic       job_complete,
    input  logic       job_complete_ack,
    output job_state_t job_state
);

    job_state_t      phase;
    job_dims_t       dims;
    tracker_status_t trk_status;
    seq_status_t     seq_status;
    logic            word_take;

    assign job_state = phase;

    // Job flow
    job_fsm job_fsm_i (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .dims_in          (job_dims),
        .trk              (trk_status),
        .seq              (seq_status),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .phase            (phase),
        .dims             (dims)
    );

    // Fetch and prefetch buffer side
    input_row_tracker input_row_tracker_i (
        .clk                   (clk),
        .rst                   (rst),
        .phase                 (phase),
        .dims                  (dims),
        .word_take             (word_take),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .pfb_rden              (pfb_rden),
        .gray_code             (gray_code),
        .status                (trk_status)
    );

    // Sequence reads and engine execute
    exec_sequencer exec_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .dims         (dims),
        .buffer_empty (trk_status.buffer_empty),
        .seq_rden     (seq_rden),
        .seq_rd_addr  (seq_rd_addr),
        .ce_execute   (ce_execute),
        .word_take    (word_take),
        .status       (seq_status)
    );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 8;

    // Free running 10 ns clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verification/quad_bram_ctrl_tb.sv */
`timescale 1ns/1ps

module quad_bram_ctrl_tb import quad_ctrl_pkg::*; ();

    localparam int NUM_JOBS = 12;
    // Generous bound per job
    localparam int JOB_CYCLES = 2000;

    logic       clk;
    logic       rst;
    job_dims_t  job_dims;
    logic       job_start;
    logic       job_accept;
    logic       job_fetch_request;
    logic       job_fetch_ack;
    logic       job_fetch_complete;
    logic       job_fetch_in_progress;
    logic       pfb_rden;
    gray_t      gray_code;
    logic       seq_rden;
    seq_addr_t  seq_rd_addr;
    ce_vec_t    ce_execute;
    logic       job_complete;
    logic       job_complete_ack;
    job_state_t job_state;

    integer seed = 32'h711b6283;
    int n_checks = 0;
    int n_errors = 0;

    // Model state
    job_dims_t                   cur_dims = '0;
    word_count_t                 m_count = '0;
    logic                        m_ip = 1'b0;
    logic                        prev_req = 1'b0;
    logic                        prev_ack = 1'b0;
    seq_addr_t                   m_addr = '0;
    pos_t                        m_col = '0;
    int                          m_reads = 0;
    ce_vec_t                     m_ce = '0;
    ce_vec_t                     exp_ce = '0;
    logic [SEQ_READ_LATENCY-1:0] rd_hist = '0;
    int                          n_drained = 0;
    // Per job totals
    int                          n_fetch = 0;
    int                          n_rden = 0;
    int                          n_seq = 0;
    int                          ack_delay;
    int                          done_delay;

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    quad_bram_ctrl dut_i (
        .clk                   (clk),
        .rst                   (rst),
        .job_dims              (job_dims),
        .job_start             (job_start),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_fetch_in_progress (job_fetch_in_progress),
        .pfb_rden              (pfb_rden),
        .gray_code             (gray_code),
        .seq_rden              (seq_rden),
        .seq_rd_addr           (seq_rd_addr),
        .ce_execute            (ce_execute),
        .job_complete          (job_complete),
        .job_complete_ack      (job_complete_ack),
        .job_state             (job_state)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int pick_between(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Binary to reflected Gray
    function automatic gray_t to_gray(input logic [1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    task automatic flag_error(input string what);
        n_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_gray(input string name, input gray_t got, input gray_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input seq_addr_t got, input seq_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ce(input string name, input ce_vec_t got, input ce_vec_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input word_count_t got,
                               input word_count_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////
    // Fetch responder
    ////////////////////

    // Random ack and complete delays, one fetch at a time
    always begin
        @(negedge clk);
        if (!rst && job_fetch_request) begin
            ack_delay = pick_between(0, 6);
            done_delay = pick_between(0, 6);
            repeat (ack_delay) @(negedge clk);
            @(posedge clk);
            job_fetch_ack <= 1'b1;
            @(posedge clk);
            job_fetch_ack <= 1'b0;
            repeat (done_delay) @(posedge clk);
            job_fetch_complete <= 1'b1;
            @(posedge clk);
            job_fetch_complete <= 1'b0;
        end
    end

    ////////////////////
    // Monitor and model
    ////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            // Request drops only the cycle after ack
            if (prev_req) begin
                check_bit("job_fetch_request", job_fetch_request, !prev_ack);
            end
            if (job_fetch_request && m_ip) begin
                flag_error("fetch request raised while a fetch is in progress");
            end
            check_bit("job_fetch_in_progress", job_fetch_in_progress, m_ip);

            // Buffer word count
            if (pfb_rden) begin
                n_rden++;
                if (m_count == '0) begin
                    flag_error("pfb_rden strobed with an empty buffer");
                end
            end
            if (m_ip && job_fetch_complete) begin
                m_count = word_count_t'(cur_dims.last_col) + word_count_t'(1);
            end else if (pfb_rden && (m_count != '0)) begin
                // Last word of a row flips the bank
                if (m_count == word_count_t'(1)) begin
                    n_drained++;
                end
                m_count = m_count - word_count_t'(1);
            end

            // Fetch in progress from ack to complete
            if (job_fetch_request && job_fetch_ack) begin
                m_ip = 1'b1;
                n_fetch++;
            end else if (m_ip && job_fetch_complete) begin
                m_ip = 1'b0;
            end
            prev_req = job_fetch_request;
            prev_ack = job_fetch_ack;

            // Sequence reads, a word taken on the last read of each pixel
            if (seq_rden) begin
                check_addr("seq_rd_addr", seq_rd_addr, m_addr);
                check_bit("pfb_rden", pfb_rden, m_reads == SEQ_READS_PER_PIXEL - 1);
                n_seq++;
                if (m_reads == SEQ_READS_PER_PIXEL - 1) begin
                    m_reads = 0;
                    if (m_col == cur_dims.last_col) begin
                        m_col = '0;
                        m_addr = '0;
                    end else begin
                        m_col = m_col + pos_t'(1);
                        m_addr = m_addr + seq_addr_t'(1);
                    end
                end else begin
                    m_reads++;
                    m_addr = m_addr + seq_addr_t'(1);
                end
            end else if (pfb_rden && (job_state != st_prime)) begin
                flag_error("pfb_rden outside prime without a sequence read");
            end

            // Execute chain behind the read pipe
            exp_ce = {m_ce[NUM_CE-2:0], rd_hist[SEQ_READ_LATENCY-1]};
            check_ce("ce_execute", ce_execute, exp_ce);
            m_ce = exp_ce;
            rd_hist = {rd_hist[SEQ_READ_LATENCY-2:0], seq_rden};
        end
    end

    ////////////////////
    // Jobs
    ////////////////////

    task automatic run_job(input int idx);
        job_dims_t d;
        int        errs_before;
        int        rows;
        int        cols;
        int        pixels;
        int        hold;
        int        k;
        d.last_row = pos_t'(pick_between(PRIME_ROWS, 6));
        d.last_col = pos_t'(pick_between(1, 7));
        rows = int'(d.last_row) + 1;
        cols = int'(d.last_col) + 1;
        pixels = (rows - PRIME_ROWS) * cols;
        errs_before = n_errors;
        @(posedge clk);
        cur_dims = d;
        m_addr = '0;
        m_col = '0;
        m_reads = 0;
        n_fetch = 0;
        n_rden = 0;
        n_seq = 0;
        job_dims <= d;
        job_start <= 1'b1;
        // Start sampled in idle on this edge
        @(posedge clk);
        job_start <= 1'b0;
        for (k = 0; k <= ACCEPT_CYCLES; k++) begin
            @(negedge clk);
            check_bit("job_accept", job_accept, k < ACCEPT_CYCLES);
        end
        while (!job_complete) begin
            @(negedge clk);
        end
        check_bit("job_state done", job_state == st_done, 1'b1);
        check_gray("gray_code", gray_code, to_gray(2'(n_drained % 4)));
        // Completion level holds until ack
        hold = pick_between(0, 6);
        repeat (hold) begin
            @(negedge clk);
            check_bit("job_complete", job_complete, 1'b1);
        end
        @(posedge clk);
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
        @(negedge clk);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("job_state idle", job_state == st_idle, 1'b1);
        check_count("fetch count", word_count_t'(n_fetch), word_count_t'(rows));
        check_count("pfb_rden count", word_count_t'(n_rden), word_count_t'(rows * cols));
        check_count("seq_rden count", word_count_t'(n_seq),
                    word_count_t'(pixels * SEQ_READS_PER_PIXEL));
        if (n_errors == errs_before) begin
            $display("job %0d (last row %0d, last col %0d): ok", idx, d.last_row, d.last_col);
        end else begin
            $display("job %0d (last row %0d, last col %0d): %0d errors", idx, d.last_row,
                     d.last_col, n_errors - errs_before);
        end
    endtask

    initial begin
        int j;
        job_dims = '0;
        job_start = 1'b0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        $display("%0d jobs, %0d checks, %0d errors", NUM_JOBS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_JOBS * JOB_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", NUM_JOBS * JOB_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* build.f */
rtl/quad_ctrl_pkg.sv
rtl/input_row_tracker.sv
rtl/exec_sequencer.sv
rtl/job_fsm.sv
rtl/quad_bram_ctrl.sv
verification/tb_clk_gen.sv
verification/quad_bram_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module quad_bram_ctrl_tb -f build.f -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
